// ==== include/sdram_cfg.svh ====
// ----------------------------------------
// SDRAM controller timing, geometry and
// mode register constants, in clock cycles
// ----------------------------------------
`ifndef SDRAM_CFG_SVH
`define SDRAM_CFG_SVH

// Power-up settle delay kept short for simulation
`define SDRAM_T_INIT 40

// Command spacing
`define SDRAM_T_RP  3
`define SDRAM_T_RFC 7
`define SDRAM_T_MRD 2
`define SDRAM_T_RCD 3
`define SDRAM_T_WR  3

// CAS latency of 2 or 3
`define SDRAM_CAS_LATENCY 3

// Cycles between owed refreshes
`define SDRAM_T_REF_INTERVAL 500

// Single-location write burst, standard operation, CAS latency,
// sequential burst type, burst length 1
`define SDRAM_MODE_WORD 13'(13'h200 | (`SDRAM_CAS_LATENCY << 4))

`endif

// ==== verilog/sdram_pkg.sv ====
// ----------------------------------------
// Shared types of the SDRAM controller
// Address fields, data word, pin commands
// and controller states
// ----------------------------------------
`default_nettype none

package sdram_pkg;

    // Word address is {row, bank, column}
    typedef logic [23:0] sdram_addr_t;
    typedef logic [12:0] sdram_row_t;
    typedef logic [1:0]  sdram_bank_t;
    typedef logic [8:0]  sdram_col_t;
    typedef logic [15:0] sdram_data_t;

    // Pin pattern {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_INHIBIT   = 4'b1111,
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_t;

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_PRECHARGE,
        ST_INIT_REFRESH1,
        ST_INIT_REFRESH2,
        ST_INIT_LOAD_MODE,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVE,
        ST_READ,
        ST_WRITE
    } fsm_state_t;

endpackage

`default_nettype wire

// ==== verilog/sdram_refresh_timer.sv ====
// ----------------------------------------
// Refresh interval counter and count of
// refreshes still owed
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_refresh_timer (
    input  wire  clk,
    input  wire  reset,
    input  wire  init_done,
    input  wire  refresh_issued,
    output logic refresh_owed
);
    localparam int INTERVAL_W = $clog2(`SDRAM_T_REF_INTERVAL);
    localparam int OWED_W     = 8;

    logic [INTERVAL_W-1:0] interval_cnt;
    logic [OWED_W-1:0]     owed_cnt;
    logic                  expired;

    assign expired      = init_done && (interval_cnt == '0);
    assign refresh_owed = (owed_cnt != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interval_cnt <= INTERVAL_W'(`SDRAM_T_REF_INTERVAL - 1);
            owed_cnt     <= '0;
        end else begin
            // Held until the power-up sequence is over
            if (expired) begin
                interval_cnt <= INTERVAL_W'(`SDRAM_T_REF_INTERVAL - 1);
            end else if (init_done) begin
                interval_cnt <= interval_cnt - 1'b1;
            end
            if (expired && !refresh_issued) begin
                owed_cnt <= owed_cnt + 1'b1;
            end else if (!expired && refresh_issued) begin
                owed_cnt <= owed_cnt - 1'b1;
            end
        end
    end

    a_owed_no_underflow: assert property (@(posedge clk) disable iff (reset)
        refresh_issued |-> (owed_cnt != '0))
        else $error("refresh issued with none owed");

endmodule

`default_nettype wire

// ==== verilog/sdram_phy_io.sv ====
// ----------------------------------------
// SDRAM pin stage
// Registered command pins, DQ tristate,
// read capture and response pulse
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_phy_io (
    input  wire                         clk,
    input  wire                         reset,
    input  wire sdram_pkg::sdram_cmd_t  cmd,
    input  wire sdram_pkg::sdram_row_t  addr_pins,
    input  wire sdram_pkg::sdram_bank_t bank_pins,
    input  wire sdram_pkg::sdram_data_t wr_data,
    input  wire                         wr_en,
    output logic                        rsp_valid,
    output sdram_pkg::sdram_data_t      rd_data,
    output logic                        cke,
    output logic                        cs_n,
    output logic                        ras_n,
    output logic                        cas_n,
    output logic                        we_n,
    output sdram_pkg::sdram_row_t       a,
    output sdram_pkg::sdram_bank_t      ba,
    output logic                        dqm,
    inout  wire sdram_pkg::sdram_data_t dq
);
    import sdram_pkg::*;

    localparam int CL = `SDRAM_CAS_LATENCY;

    // Entry k is the access whose command was on the pins k cycles ago
    logic [CL:0] acc_pipe;
    logic [CL:0] rd_pipe;
    logic        read_capture;
    logic        write_done;
    logic        dq_oe;
    sdram_data_t dq_out;

    assign read_capture = acc_pipe[CL] && rd_pipe[CL];
    assign write_done   = acc_pipe[0] && !rd_pipe[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {cs_n, ras_n, cas_n, we_n} <= CMD_INHIBIT;
            cke       <= 1'b1;
            dqm       <= 1'b1;
            dq_oe     <= 1'b0;
            acc_pipe  <= '0;
            rd_pipe   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            {cs_n, ras_n, cas_n, we_n} <= cmd;
            cke       <= 1'b1;
            // Data masked while the device is still powering up
            dqm       <= (cmd == CMD_INHIBIT);
            dq_oe     <= wr_en;
            acc_pipe  <= {acc_pipe[CL-1:0], cmd inside {CMD_READ, CMD_WRITE}};
            rd_pipe   <= {rd_pipe[CL-1:0], cmd == CMD_READ};
            rsp_valid <= read_capture || write_done;
        end
    end

    always_ff @(posedge clk) begin
        a      <= addr_pins;
        ba     <= bank_pins;
        dq_out <= wr_data;
        if (read_capture) begin
            rd_data <= dq;
        end
    end

    assign dq = dq_oe ? dq_out : 'z;

    a_no_drive_during_read: assert property (@(posedge clk) disable iff (reset)
        (|(acc_pipe & rd_pipe)) |-> !dq_oe)
        else $error("DQ driven while read data is pending");

endmodule

`default_nettype wire

// ==== verilog/sdram_cmd_fsm.sv ====
// ----------------------------------------
// SDRAM command FSM
// Power-up sequence, refresh and single
// word accesses with auto-precharge
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_cmd_fsm (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         req_valid,
    input  wire                         req_write,
    input  wire sdram_pkg::sdram_addr_t req_addr,
    input  wire sdram_pkg::sdram_data_t req_wdata,
    input  wire                         refresh_owed,
    output logic                        req_ready,
    output logic                        refresh_issued,
    output logic                        init_done,
    output sdram_pkg::sdram_cmd_t       cmd,
    output sdram_pkg::sdram_row_t       addr_pins,
    output sdram_pkg::sdram_bank_t      bank_pins,
    output sdram_pkg::sdram_data_t      wr_data,
    output logic                        wr_en
);
    import sdram_pkg::*;

    // Access states last until the auto-precharge is done and the response is out
    localparam int READ_WAIT  = `SDRAM_CAS_LATENCY + `SDRAM_T_RP + 2;
    localparam int WRITE_WAIT = `SDRAM_T_WR + `SDRAM_T_RP + 2;
    localparam int TIMER_W    = $clog2(`SDRAM_T_INIT + READ_WAIT + WRITE_WAIT + `SDRAM_T_RFC);
    localparam int A10_AP     = 10;

    fsm_state_t           state;
    fsm_state_t           next_state;
    logic                 state_entry;
    logic [TIMER_W-1:0]   timer;
    logic [TIMER_W-1:0]   wait_cycles;
    logic                 timer_done;
    logic                 req_accept;

    // Captured request
    sdram_row_t  acc_row;
    sdram_bank_t acc_bank;
    sdram_col_t  acc_col;
    logic        acc_write;
    sdram_data_t acc_wdata;

    assign timer_done = (timer == '0);
    assign req_ready  = (state == ST_IDLE) && init_done && !refresh_owed;
    assign req_accept = req_valid && req_ready;

    always_comb begin
        next_state = state;
        case (state)
            ST_INIT_WAIT:      if (timer_done) next_state = ST_INIT_PRECHARGE;
            ST_INIT_PRECHARGE: if (timer_done) next_state = ST_INIT_REFRESH1;
            ST_INIT_REFRESH1:  if (timer_done) next_state = ST_INIT_REFRESH2;
            ST_INIT_REFRESH2:  if (timer_done) next_state = ST_INIT_LOAD_MODE;
            ST_INIT_LOAD_MODE: if (timer_done) next_state = ST_IDLE;
            ST_IDLE: begin
                // Owed refresh goes first
                if (refresh_owed) begin
                    next_state = ST_REFRESH;
                end else if (req_accept) begin
                    next_state = ST_ACTIVE;
                end
            end
            ST_ACTIVE: begin
                if (timer_done) next_state = acc_write ? ST_WRITE : ST_READ;
            end
            ST_REFRESH, ST_READ, ST_WRITE: begin
                if (timer_done) next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Length of the state being entered
    always_comb begin
        case (next_state)
            ST_INIT_PRECHARGE: wait_cycles = TIMER_W'(`SDRAM_T_RP);
            ST_INIT_REFRESH1,
            ST_INIT_REFRESH2,
            ST_REFRESH:        wait_cycles = TIMER_W'(`SDRAM_T_RFC);
            ST_INIT_LOAD_MODE: wait_cycles = TIMER_W'(`SDRAM_T_MRD);
            ST_ACTIVE:         wait_cycles = TIMER_W'(`SDRAM_T_RCD);
            ST_READ:           wait_cycles = TIMER_W'(READ_WAIT);
            ST_WRITE:          wait_cycles = TIMER_W'(WRITE_WAIT);
            default:           wait_cycles = TIMER_W'(1);
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ST_INIT_WAIT;
            state_entry <= 1'b1;
            timer       <= TIMER_W'(`SDRAM_T_INIT - 1);
            init_done   <= 1'b0;
        end else begin
            state       <= next_state;
            state_entry <= (next_state != state);
            if (next_state != state) begin
                timer <= wait_cycles - 1'b1;
            end else if (!timer_done) begin
                timer <= timer - 1'b1;
            end
            if (state == ST_INIT_LOAD_MODE && timer_done) begin
                init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            {acc_row, acc_bank, acc_col} <= req_addr;
            acc_write <= req_write;
            acc_wdata <= req_wdata;
        end
    end

    // ----------------------------------------
    // Command decode on state entry
    // ----------------------------------------
    always_comb begin
        cmd       = CMD_NOP;
        addr_pins = '0;
        bank_pins = '0;
        if (state == ST_INIT_WAIT) begin
            cmd = CMD_INHIBIT;
        end else if (state_entry) begin
            case (state)
                ST_INIT_PRECHARGE: begin
                    cmd               = CMD_PRECHARGE;
                    addr_pins[A10_AP] = 1'b1;
                end
                ST_INIT_REFRESH1, ST_INIT_REFRESH2, ST_REFRESH: cmd = CMD_REFRESH;
                ST_INIT_LOAD_MODE: begin
                    cmd       = CMD_LOAD_MODE;
                    addr_pins = `SDRAM_MODE_WORD;
                end
                ST_ACTIVE: begin
                    cmd       = CMD_ACTIVE;
                    addr_pins = acc_row;
                    bank_pins = acc_bank;
                end
                ST_READ, ST_WRITE: begin
                    cmd               = (state == ST_WRITE) ? CMD_WRITE : CMD_READ;
                    addr_pins[8:0]    = acc_col;
                    addr_pins[A10_AP] = 1'b1;
                    bank_pins         = acc_bank;
                end
                default: cmd = CMD_NOP;
            endcase
        end
    end

    // Init refreshes are not owed, so only the periodic ones are reported
    assign refresh_issued = (state == ST_REFRESH) && state_entry;
    assign wr_en          = (state == ST_WRITE) && state_entry;
    assign wr_data        = acc_wdata;

    a_no_accept_when_owed: assert property (@(posedge clk) disable iff (reset)
        (state == ST_ACTIVE && state_entry) |-> $past(!refresh_owed))
        else $error("request accepted while a refresh was owed");

    a_rcd_before_access: assert property (@(posedge clk) disable iff (reset)
        (cmd inside {CMD_READ, CMD_WRITE}) |-> $past(cmd == CMD_ACTIVE, `SDRAM_T_RCD))
        else $error("READ/WRITE issued without tRCD after ACTIVE");

endmodule

`default_nettype wire

// ==== verilog/sdram_ctrl_top.sv ====
// ----------------------------------------
// SDRAM controller top level
// Command FSM, refresh timer and pin stage
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     req_valid,
    output wire                     req_ready,
    input  wire                     req_write,
    input  wire sdram_pkg::sdram_addr_t req_addr,
    input  wire sdram_pkg::sdram_data_t req_wdata,
    output wire                     rsp_valid,
    output wire sdram_pkg::sdram_data_t rd_data,
    output wire                     cke,
    output wire                     cs_n,
    output wire                     ras_n,
    output wire                     cas_n,
    output wire                     we_n,
    output wire sdram_pkg::sdram_row_t  a,
    output wire sdram_pkg::sdram_bank_t ba,
    output wire                     dqm,
    inout  wire sdram_pkg::sdram_data_t dq
);
    import sdram_pkg::*;

    logic        init_done;
    logic        refresh_owed;
    logic        refresh_issued;
    sdram_cmd_t  cmd;
    sdram_row_t  addr_pins;
    sdram_bank_t bank_pins;
    sdram_data_t wr_data;
    logic        wr_en;

    sdram_cmd_fsm sdram_cmd_fsm_i (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .refresh_owed   (refresh_owed),
        .req_ready      (req_ready),
        .refresh_issued (refresh_issued),
        .init_done      (init_done),
        .cmd            (cmd),
        .addr_pins      (addr_pins),
        .bank_pins      (bank_pins),
        .wr_data        (wr_data),
        .wr_en          (wr_en)
    );

    sdram_refresh_timer sdram_refresh_timer_i (
        .clk            (clk),
        .reset          (reset),
        .init_done      (init_done),
        .refresh_issued (refresh_issued),
        .refresh_owed   (refresh_owed)
    );

    sdram_phy_io sdram_phy_io_i (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .addr_pins (addr_pins),
        .bank_pins (bank_pins),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .rsp_valid (rsp_valid),
        .rd_data   (rd_data),
        .cke       (cke),
        .cs_n      (cs_n),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .we_n      (we_n),
        .a         (a),
        .ba        (ba),
        .dqm       (dqm),
        .dq        (dq)
    );

endmodule

`default_nettype wire

// ==== test/sdram_model.sv ====
// ----------------------------------------
// Behavioral SDRAM memory
// Decodes pin commands, returns read data
// after the CAS latency
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sdram_cfg.svh"

module sdram_model (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         cke,
    input  wire                         cs_n,
    input  wire                         ras_n,
    input  wire                         cas_n,
    input  wire                         we_n,
    input  wire sdram_pkg::sdram_row_t  a,
    input  wire sdram_pkg::sdram_bank_t ba,
    input  wire                         dqm,
    inout  wire sdram_pkg::sdram_data_t dq
);
    import sdram_pkg::*;

    localparam int CL = `SDRAM_CAS_LATENCY;

    sdram_data_t   mem [sdram_addr_t];
    sdram_row_t    open_row [4];
    logic [CL-1:0] rd_pipe;
    sdram_data_t   rd_word [CL];
    sdram_cmd_t    cmd;
    sdram_addr_t   addr;

    assign cmd  = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
    assign addr = {open_row[ba], ba, a[8:0]};

    // Unwritten locations return a word built from every address bit
    function automatic sdram_data_t fill_word(input sdram_addr_t x);
        return x[15:0] ^ {x[23:16], x[23:16]};
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_pipe <= '0;
        end else if (cke) begin
            rd_pipe <= {rd_pipe[CL-2:0], cmd == CMD_READ};
            for (int i = 1; i < CL; i++) begin
                rd_word[i] <= rd_word[i-1];
            end
            case (cmd)
                CMD_ACTIVE: open_row[ba] <= a;
                CMD_READ:   rd_word[0] <= mem.exists(addr) ? mem[addr] : fill_word(addr);
                CMD_WRITE:  if (!dqm) mem[addr] = dq;
                default:    ;
            endcase
        end
    end

    // Data is valid at the edge CL cycles after the READ edge
    assign dq = rd_pipe[CL-1] ? rd_word[CL-1] : 'z;

endmodule

`default_nettype wire

// ==== test/tb_sdram_ctrl.sv ====
// ----------------------------------------
// SDRAM controller testbench
// Random accesses, scoreboard, command
// order and timing assertions
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sdram_cfg.svh"

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int         WAIT_LIMIT = 200;
    localparam int         POOL_SIZE  = 16;
    localparam sdram_row_t MODE_WORD  = `SDRAM_MODE_WORD;

    logic             clk;
    logic             reset;
    logic             req_valid;
    logic             req_ready;
    logic             req_write;
    sdram_addr_t      req_addr;
    sdram_data_t      req_wdata;
    logic             rsp_valid;
    sdram_data_t      rd_data;
    logic             cke;
    logic             cs_n;
    logic             ras_n;
    logic             cas_n;
    logic             we_n;
    sdram_row_t       a;
    sdram_bank_t      ba;
    logic             dqm;
    wire sdram_data_t dq;

    // Pin monitor and scoreboard state
    sdram_cmd_t  pin_cmd;
    logic        is_cmd;
    logic [2:0]  cmd_count;
    int          cycle;
    int          last_ref_cycle;
    int          ref_count;
    int          act_cycle [4];
    logic [3:0]  act_valid;
    int          accepts;
    int          responses;
    logic        exp_read;
    sdram_data_t exp_data;
    sdram_data_t scoreboard [sdram_addr_t];
    sdram_addr_t pool [POOL_SIZE];

    sdram_ctrl_top sdram_ctrl_top_i (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
        .req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
        .rsp_valid(rsp_valid), .rd_data(rd_data), .cke(cke), .cs_n(cs_n),
        .ras_n(ras_n), .cas_n(cas_n), .we_n(we_n), .a(a), .ba(ba), .dqm(dqm), .dq(dq)
    );

    sdram_model sdram_model_i (
        .clk(clk), .reset(reset), .cke(cke), .cs_n(cs_n), .ras_n(ras_n),
        .cas_n(cas_n), .we_n(we_n), .a(a), .ba(ba), .dqm(dqm), .dq(dq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want));
    endtask

    // Drive one request until accepted and wait for its response
    task automatic do_access(input logic is_write, input sdram_addr_t addr,
                             input sdram_data_t data);
        int waited;
        req_valid <= 1'b1;
        req_write <= is_write;
        req_addr  <= addr;
        req_wdata <= data;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("request was never accepted");
        end while (!req_ready);
        req_valid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("no response to an accepted request");
        end while (!rsp_valid);
        repeat ($urandom_range(8)) @(posedge clk);
    endtask

    // ----------------------------------------
    // Pin and request monitor
    // ----------------------------------------
    assign pin_cmd = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
    assign is_cmd  = !(pin_cmd inside {CMD_NOP, CMD_INHIBIT});

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_count      <= '0;
            cycle          <= 0;
            last_ref_cycle <= 0;
            ref_count      <= 0;
            act_valid      <= '0;
            accepts        <= 0;
            responses      <= 0;
            exp_read       <= 1'b0;
        end else begin
            cycle <= cycle + 1;
            if (is_cmd && cmd_count != 3'd7) cmd_count <= cmd_count + 1'b1;
            if (pin_cmd == CMD_LOAD_MODE) last_ref_cycle <= cycle;
            if (pin_cmd == CMD_REFRESH && cmd_count >= 3'd4) begin
                ref_count      <= ref_count + 1;
                last_ref_cycle <= cycle;
            end
            if (pin_cmd == CMD_ACTIVE) begin
                act_valid[ba] <= 1'b1;
                act_cycle[ba] <= cycle;
            end
            // Auto-precharge closes the row again
            if (pin_cmd inside {CMD_READ, CMD_WRITE}) act_valid[ba] <= 1'b0;
            if (req_valid && req_ready) begin
                accepts  <= accepts + 1;
                exp_read <= !req_write;
                if (req_write) scoreboard[req_addr] = req_wdata;
                else exp_data <= scoreboard[req_addr];
            end
            if (rsp_valid) responses <= responses + 1;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_reset_pins: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (cs_n && cke && !req_ready && !rsp_valid))
        else fail_run("pins or handshake were not idle during reset");
    a_cke_high: assert property (@(posedge clk) disable iff (reset)
        cke)
        else report_mismatch("cke", $sampled(cke), 1'b1);
    a_init_precharge: assert property (@(posedge clk) disable iff (reset)
        (is_cmd && cmd_count == 3'd0) |-> (pin_cmd == CMD_PRECHARGE && a[10]))
        else report_mismatch("{cmd, a[10]}", {$sampled(pin_cmd), $sampled(a[10])},
                             {CMD_PRECHARGE, 1'b1});
    a_init_refresh: assert property (@(posedge clk) disable iff (reset)
        (is_cmd && cmd_count inside {3'd1, 3'd2}) |-> (pin_cmd == CMD_REFRESH))
        else report_mismatch("cmd", $sampled(pin_cmd), CMD_REFRESH);
    a_init_mode: assert property (@(posedge clk) disable iff (reset)
        (is_cmd && cmd_count == 3'd3) |-> ({pin_cmd, a} == {CMD_LOAD_MODE, MODE_WORD}))
        else report_mismatch("{cmd, a}", {$sampled(pin_cmd), $sampled(a)},
                             {CMD_LOAD_MODE, MODE_WORD});
    a_ready_after_init: assert property (@(posedge clk) disable iff (reset)
        req_ready |-> (cmd_count >= 3'd4))
        else fail_run("req_ready was high before LOAD_MODE reached the pins");
    a_read_data: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && exp_read) |-> (rd_data == exp_data))
        else report_mismatch("rd_data", $sampled(rd_data), $sampled(exp_data));
    a_one_response: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (accepts - responses == 1))
        else fail_run("rsp_valid came without an open request");
    a_single_in_flight: assert property (@(posedge clk) disable iff (reset)
        req_ready |-> (accepts == responses))
        else fail_run("req_ready was high while an access was still open");
    a_active_first: assert property (@(posedge clk) disable iff (reset)
        (pin_cmd inside {CMD_READ, CMD_WRITE})
        |-> (act_valid[ba] && (cycle - act_cycle[ba] >= `SDRAM_T_RCD)))
        else fail_run("READ or WRITE without an ACTIVE to its bank tRCD earlier");
    a_auto_precharge: assert property (@(posedge clk) disable iff (reset)
        (pin_cmd inside {CMD_READ, CMD_WRITE}) |-> a[10])
        else report_mismatch("a[10]", $sampled(a[10]), 1'b1);
    a_write_unmasked: assert property (@(posedge clk) disable iff (reset)
        (pin_cmd == CMD_WRITE) |-> !dqm)
        else report_mismatch("dqm", $sampled(dqm), 1'b0);
    a_refresh_gap: assert property (@(posedge clk) disable iff (reset)
        (cmd_count >= 3'd4) |-> (cycle - last_ref_cycle <= 2 * `SDRAM_T_REF_INTERVAL))
        else fail_run("too long a gap between two REFRESH commands");
    a_no_ready_on_refresh: assert property (@(posedge clk) disable iff (reset)
        (pin_cmd == CMD_REFRESH) |-> !req_ready)
        else fail_run("req_ready was high during a REFRESH");

    initial begin
        int waited;
        int idx;
        void'($urandom(32'h1fcf));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_run("initialization never finished");
        end while (!req_ready);

        // Addresses over all four banks and random rows
        foreach (pool[i]) pool[i] = {13'($urandom), 2'(i), 9'($urandom)};
        do_access(1'b1, pool[0], 16'ha5c3);
        do_access(1'b0, pool[0], '0);
        foreach (pool[i]) do_access(1'b1, pool[i], 16'($urandom));
        repeat (300) begin
            idx = $urandom_range(POOL_SIZE - 1);
            do_access(1'($urandom), pool[idx], 16'($urandom));
        end
        repeat (4) @(posedge clk);

        if (ref_count < 2) begin
            fail_run("periodic REFRESH commands did not appear");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
verilog/sdram_pkg.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_phy_io.sv
verilog/sdram_cmd_fsm.sv
verilog/sdram_ctrl_top.sv
test/sdram_model.sv
test/tb_sdram_ctrl.sv
